// ==== common/imagePkg.sv ====
`default_nettype none

package imagePkg;

    // ------------------------------------------------------------------------
    // frame geometry
    localparam int frameWidth   = 4;                            // pixels per row, even
    localparam int frameHeight  = 2;                            // rows per frame
    localparam int pairCount    = frameWidth * frameHeight / 2; // two pixels per clock
    localparam int pairIdxWidth = 2;                            // covers 0..pairCount-1

    // pixel limits
    localparam int pixMax       = 255;                          // clamp ceiling, invert base
    localparam int pixMid       = 128;                          // contrast pivot
    localparam int gainFracBits = 4;                            // contrast gain is 4.4

    // ------------------------------------------------------------------------
    // operation codes
    localparam logic [2:0] opBrightness = 3'd0;                 // add/sub with clamp
    localparam logic [2:0] opInvert     = 3'd1;                 // 255 - grey
    localparam logic [2:0] opThreshold  = 3'd2;                 // black or white
    localparam logic [2:0] opContrast   = 3'd3;                 // fixed point gain
    localparam logic [2:0] opPass       = 3'd7;                 // unknown codes land here

    // 4.4 unsigned gain
    typedef struct packed {
        logic [3:0] intPart;                                    // whole part
        logic [3:0] fracPart;                                   // sixteenths
    } gainT;

    // one adjust word, two readings
    typedef union packed {
        logic [7:0] amount;                                     // brightness, threshold
        gainT       gain;                                       // contrast
    } adjustWordT;

endpackage

`default_nettype wire

// ==== common/opCtrlIf.sv ====
`default_nettype none

// static operation controls, decode to pixel ALUs
interface opCtrlIf;

    logic [2:0]     opSel;                  // decoded op, opPass when unknown
    logic           addMode;                // 1 add, 0 subtract
    logic [7:0]     amount;                 // brightness step or threshold
    imagePkg::gainT gain;                   // contrast gain

    modport decode (output opSel, output addMode, output amount, output gain);

    modport alu (input opSel, input addMode, input amount, input gain);

endinterface

`default_nettype wire

// ==== common/pixelPairIf.sv ====
`default_nettype none

// processed pixel pair, execute to result register
interface pixelPairIf;

    logic [7:0] r0, g0, b0;                 // even pixel
    logic [7:0] r1, g1, b1;                 // odd pixel
    logic       pairValid;                  // channels meaningful this cycle
    logic       lastPair;                   // final pair of the frame

    modport exec (output r0, g0, b0, r1, g1, b1, pairValid, lastPair);

    modport result (input r0, g0, b0, r1, g1, b1, pairValid, lastPair);

endinterface

`default_nettype wire

// ==== compile.f ====
common/imagePkg.sv
common/opCtrlIf.sv
common/pixelPairIf.sv
hdl/frameScan.sv
hdl/opDecode.sv
pixelExec/pixelAlu.sv
pixelExec/pixelPairExec.sv
hdl/resultStage.sv
hdl/imageProcessor.sv
testbench/tbImageProcessor.sv

// ==== hdl/frameScan.sv ====
`default_nettype none

module frameScan (
    input  wire logic                              HCLK,
    input  wire logic                              HRESETn,
    output logic     [imagePkg::pairIdxWidth-1:0]  pairAddr,    // pair being requested
    output logic                                   scanActive,  // data state
    output logic                                   lastPair     // final index on pairAddr
);

    logic resetSeen;                            // high from first edge after release
    logic startPulse;                           // single cycle, once per reset
    logic inData;                               // 0 idle, 1 data
    logic atLast;                               // counter holds the final index

    // ------------------------------------------------------------------------
    // start pulse, one clock after reset release
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            resetSeen  <= 1'b0;
            startPulse <= 1'b0;
        end else begin
            resetSeen  <= 1'b1;
            startPulse <= !resetSeen;           // only the first edge sees resetSeen low
        end
    end

    assign atLast = inData &&
                    (pairAddr == imagePkg::pairIdxWidth'(imagePkg::pairCount - 1));

    // ------------------------------------------------------------------------
    // idle/data state, no way back to data without a new reset
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            inData <= 1'b0;
        end else if (!inData && startPulse) begin
            inData <= 1'b1;                     // idle -> data
        end else if (atLast) begin
            inData <= 1'b0;                     // frame finished, park in idle
        end
    end

    // pair counter, one step per data cycle
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            pairAddr <= '0;
        end else if (inData) begin
            pairAddr <= atLast ? '0 : pairAddr + 1'b1;  // wrap so idle sits at 0
        end
    end

    assign scanActive = inData;
    assign lastPair   = atLast;

endmodule

`default_nettype wire

// ==== hdl/imageProcessor.sv ====
`default_nettype none

module imageProcessor (
    input  wire logic                              HCLK,
    input  wire logic                              HRESETn,
    input  wire logic [2:0]                        operation,   // held for a frame
    input  wire logic                              adjustSign,  // 1 add, 0 subtract
    input  wire logic [7:0]                        adjustValue, // amount or 4.4 gain
    output logic      [imagePkg::pairIdxWidth-1:0] pairAddr,    // pair request
    input  wire logic [7:0]                        inR0, inG0, inB0,
    input  wire logic [7:0]                        inR1, inG1, inB1,
    output logic                                   dataWrite,
    output logic                                   ctrlDone,
    output logic      [7:0]                        outR0, outG0, outB0,
    output logic      [7:0]                        outR1, outG1, outB1
);

    logic scanActive;                           // data state
    logic lastPair;                             // final index on pairAddr

    opCtrlIf    opCtrl ();                      // decode -> ALUs
    pixelPairIf pixPair ();                     // execute -> result

    // ------------------------------------------------------------------------
    frameScan uFrameScan (.HCLK(HCLK), .HRESETn(HRESETn), .pairAddr(pairAddr),
                          .scanActive(scanActive), .lastPair(lastPair));

    opDecode uOpDecode (.operation(operation), .adjustSign(adjustSign),
                        .adjustValue(adjustValue), .ctrl(opCtrl.decode));

    pixelPairExec uPairExec (
        .inR0(inR0), .inG0(inG0), .inB0(inB0),
        .inR1(inR1), .inG1(inG1), .inB1(inB1),
        .scanActive(scanActive), .lastPair(lastPair),
        .ctrl(opCtrl.alu), .pair(pixPair.exec)
    );

    resultStage uResult (
        .HCLK(HCLK), .HRESETn(HRESETn), .pair(pixPair.result),
        .dataWrite(dataWrite), .ctrlDone(ctrlDone),
        .outR0(outR0), .outG0(outG0), .outB0(outB0),
        .outR1(outR1), .outG1(outG1), .outB1(outB1)
    );

endmodule

`default_nettype wire

// ==== hdl/opDecode.sv ====
`default_nettype none

module opDecode (
    input wire logic [2:0]           operation,     // raw op code from the port
    input wire logic                 adjustSign,    // 1 brighten, 0 darken
    input wire imagePkg::adjustWordT adjustValue,   // amount or 4.4 gain
    opCtrlIf.decode                  ctrl
);

    // ------------------------------------------------------------------------
    // op select, anything outside the known set becomes pass-through
    always_comb begin
        case (operation)
            imagePkg::opBrightness,
            imagePkg::opInvert,
            imagePkg::opThreshold,
            imagePkg::opContrast: begin
                ctrl.opSel = operation;             // supported op
            end
            default: begin
                ctrl.opSel = imagePkg::opPass;      // pixels go through untouched
            end
        endcase
    end

    assign ctrl.addMode = adjustSign;               // brightness direction

    // same word, read once as amount and once as gain
    assign ctrl.amount  = adjustValue.amount;
    assign ctrl.gain    = adjustValue.gain;

endmodule

`default_nettype wire

// ==== hdl/resultStage.sv ====
`default_nettype none

module resultStage (
    input  wire logic       HCLK,
    input  wire logic       HRESETn,
    pixelPairIf.result      pair,
    output logic            dataWrite,          // pair on the outputs is valid
    output logic            ctrlDone,           // pair on the outputs is the last
    output logic      [7:0] outR0, outG0, outB0,
    output logic      [7:0] outR1, outG1, outB1
);

    // ------------------------------------------------------------------------
    // one cycle behind the address, everything clears on reset
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            dataWrite <= 1'b0;
            ctrlDone  <= 1'b0;
            outR0     <= 8'd0;
            outG0     <= 8'd0;
            outB0     <= 8'd0;
            outR1     <= 8'd0;
            outG1     <= 8'd0;
            outB1     <= 8'd0;
        end else begin
            dataWrite <= pair.pairValid;        // strobe follows the scan
            ctrlDone  <= pair.lastPair;         // single cycle, with the last pair
            outR0     <= pair.r0;
            outG0     <= pair.g0;
            outB0     <= pair.b0;
            outR1     <= pair.r1;
            outG1     <= pair.g1;
            outB1     <= pair.b1;
        end
    end

endmodule

`default_nettype wire

// ==== pixelExec/pixelAlu.sv ====
`default_nettype none

module pixelAlu (
    opCtrlIf.alu           ctrl,
    input  wire logic [7:0] inR,
    input  wire logic [7:0] inG,
    input  wire logic [7:0] inB,
    output logic      [7:0] outR,
    output logic      [7:0] outG,
    output logic      [7:0] outB
);

    logic [9:0] rgbSum;                             // up to 3*255
    logic [7:0] avg;                                // floored grey level
    logic [7:0] greyInv;
    logic [7:0] greyBin;

    // brightness step, clamped to 0..pixMax
    function automatic logic [7:0] brightChan(input logic [7:0] ch, input logic [7:0] amt,
                                               input logic addMode);
        logic [8:0] sum;
        logic [8:0] diff;
        sum  = {1'b0, ch} + {1'b0, amt};
        diff = {1'b0, ch} - {1'b0, amt};
        if (addMode) begin
            brightChan = sum[8] ? 8'(imagePkg::pixMax) : sum[7:0];  // carry means overflow
        end else begin
            brightChan = diff[8] ? 8'd0 : diff[7:0];                // borrow means underflow
        end
    endfunction

    // pixMid + ((ch - pixMid) * gain) >>> fracBits, then clamp
    function automatic logic [7:0] contrastChan(input logic [7:0] ch, input logic [7:0] gainWord);
        logic signed [8:0]  centered;
        logic signed [17:0] scaled;
        logic signed [17:0] shifted;
        centered = $signed({1'b0, ch}) - 9'(imagePkg::pixMid);      // -128..127
        scaled   = centered * $signed({1'b0, gainWord});
        shifted  = (scaled >>> imagePkg::gainFracBits) + 18'(imagePkg::pixMid);  // floors
        if (shifted < 18'sd0) begin
            contrastChan = 8'd0;
        end else if (shifted > 18'(imagePkg::pixMax)) begin
            contrastChan = 8'(imagePkg::pixMax);
        end else begin
            contrastChan = shifted[7:0];
        end
    endfunction

    // ------------------------------------------------------------------------
    // grey level shared by invert and threshold
    assign rgbSum  = {2'b00, inR} + {2'b00, inG} + {2'b00, inB};
    assign avg     = 8'(rgbSum / 10'd3);
    assign greyInv = 8'(imagePkg::pixMax) - avg;
    assign greyBin = (avg > ctrl.amount) ? 8'(imagePkg::pixMax) : 8'd0;  // equal stays black

    always_comb begin
        outR = inR;                                 // pass-through unless an op hits
        outG = inG;
        outB = inB;
        case (ctrl.opSel)
            imagePkg::opBrightness: begin
                outR = brightChan(inR, ctrl.amount, ctrl.addMode);
                outG = brightChan(inG, ctrl.amount, ctrl.addMode);
                outB = brightChan(inB, ctrl.amount, ctrl.addMode);
            end
            imagePkg::opInvert: begin
                outR = greyInv;
                outG = greyInv;
                outB = greyInv;
            end
            imagePkg::opThreshold: begin
                outR = greyBin;
                outG = greyBin;
                outB = greyBin;
            end
            imagePkg::opContrast: begin
                outR = contrastChan(inR, {ctrl.gain.intPart, ctrl.gain.fracPart});
                outG = contrastChan(inG, {ctrl.gain.intPart, ctrl.gain.fracPart});
                outB = contrastChan(inB, {ctrl.gain.intPart, ctrl.gain.fracPart});
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== pixelExec/pixelPairExec.sv ====
`default_nettype none

module pixelPairExec (
    input  wire logic [7:0] inR0, inG0, inB0,   // even pixel from source
    input  wire logic [7:0] inR1, inG1, inB1,   // odd pixel from source
    input  wire logic       scanActive,         // data state
    input  wire logic       lastPair,           // final index on the address
    opCtrlIf.alu            ctrl,
    pixelPairIf.exec        pair
);

    logic [7:0] aluR0, aluG0, aluB0;            // even ALU result
    logic [7:0] aluR1, aluG1, aluB1;            // odd ALU result

    pixelAlu uAluEven (.ctrl(ctrl), .inR(inR0), .inG(inG0), .inB(inB0),
                       .outR(aluR0), .outG(aluG0), .outB(aluB0));

    pixelAlu uAluOdd (.ctrl(ctrl), .inR(inR1), .inG(inG1), .inB(inB1),
                      .outR(aluR1), .outG(aluG1), .outB(aluB1));

    // zero the channels outside the data state
    assign pair.r0        = scanActive ? aluR0 : 8'd0;
    assign pair.g0        = scanActive ? aluG0 : 8'd0;
    assign pair.b0        = scanActive ? aluB0 : 8'd0;
    assign pair.r1        = scanActive ? aluR1 : 8'd0;
    assign pair.g1        = scanActive ? aluG1 : 8'd0;
    assign pair.b1        = scanActive ? aluB1 : 8'd0;
    assign pair.pairValid = scanActive;
    assign pair.lastPair  = lastPair;

endmodule

`default_nettype wire

// ==== runSim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tbImageProcessor \
    -f compile.f -Mdir obj_dir -o simImage || exit 1
./obj_dir/simImage | tee /dev/stderr | grep -qx "Simulation passed" && echo "run ok" || exit 1

// ==== testbench/imageGolden.hex ====
// test op sign adj idx | in r0 g0 b0 r1 g1 b1 | expected r0 g0 b0 r1 g1 b1
// tests: 0 bright add 100, 1 bright sub 100, 2 invert, 3 threshold 90, 4 contrast 2.5
00 00 01 64 00 0a 14 1e 9b 9c c8 6e 78 82 ff ff ff
00 00 01 64 01 00 64 9a ff 32 01 64 c8 fe ff 96 65
00 00 01 64 02 80 40 20 5a 5b 5c e4 a4 84 be bf c0
00 00 01 64 03 c8 63 9b 07 08 09 ff c7 ff 6b 6c 6d
01 00 00 64 00 0a 14 1e 9b 9c c8 00 00 00 37 38 64
01 00 00 64 01 64 65 63 ff 00 80 00 01 00 9b 00 1c
01 00 00 64 02 c8 96 fa 40 20 10 64 32 96 00 00 00
01 00 00 64 03 65 66 67 b4 be aa 01 02 03 50 5a 46
02 01 00 00 00 00 00 00 ff ff ff ff ff ff 00 00 00
02 01 00 00 01 0a 14 1f 64 32 01 eb eb eb cd cd cd
02 01 00 00 02 c8 64 32 01 01 00 8b 8b 8b ff ff ff
02 01 00 00 03 ff fe 00 80 80 81 56 56 56 7f 7f 7f
03 02 00 5a 00 5a 5a 5a 5b 5a 5a 00 00 00 00 00 00
03 02 00 5a 01 5b 5b 5b 5c 5b 5a ff ff ff ff ff ff
03 02 00 5a 02 00 00 ff ff 00 1e 00 00 00 ff ff ff
03 02 00 5a 03 c8 c8 c8 0a 14 1e ff ff ff 00 00 00
04 03 00 28 00 80 82 7f 64 96 4d 80 85 7d 3a b7 00
04 03 00 28 01 4c b4 b3 b2 00 ff 00 ff ff fd 00 ff
04 03 00 28 02 81 7e 78 65 80 80 82 7b 6c 3c 80 80
04 03 00 28 03 8c 6e a0 32 c8 5a 9e 53 d0 00 ff 21

// ==== testbench/tbImageProcessor.sv ====
`default_nettype none

module tbImageProcessor;

    localparam int clkPeriod     = 40;
    localparam int resetCycles   = 8;
    localparam int quietCycles   = 2;               // idle cycles watched after done
    localparam int numTests      = 5;
    localparam int numLines      = numTests * imagePkg::pairCount;
    localparam int fieldsPerLine = 17;              // test op sign adj idx, 6 in, 6 out
    localparam int frameLimit    = imagePkg::pairCount + 6;
    localparam int watchdogTime  =
        numTests * (resetCycles + imagePkg::pairCount + 6) * clkPeriod;

    logic                              HCLK;
    logic                              HRESETn;
    logic [2:0]                        operation;
    logic                              adjustSign;
    logic [7:0]                        adjustValue;
    logic [imagePkg::pairIdxWidth-1:0] pairAddr;
    logic [7:0]                        inR0, inG0, inB0;
    logic [7:0]                        inR1, inG1, inB1;
    logic                              dataWrite;
    logic                              ctrlDone;
    logic [7:0]                        outR0, outG0, outB0;
    logic [7:0]                        outR1, outG1, outB1;

    logic [7:0] golden [0:numLines*fieldsPerLine-1];   // flat, one byte per field
    string      testNames [0:numTests-1];
    int         testIdx;                            // frame being run
    int         writeCount;                         // dataWrite strobes seen this frame
    int         errorCount;
    logic       prevWrite;                          // dataWrite one cycle back
    logic       doneSeen;

    imageProcessor u_imageProcessor (
        .HCLK(HCLK), .HRESETn(HRESETn),
        .operation(operation), .adjustSign(adjustSign), .adjustValue(adjustValue),
        .pairAddr(pairAddr),
        .inR0(inR0), .inG0(inG0), .inB0(inB0),
        .inR1(inR1), .inG1(inG1), .inB1(inB1),
        .dataWrite(dataWrite), .ctrlDone(ctrlDone),
        .outR0(outR0), .outG0(outG0), .outB0(outB0),
        .outR1(outR1), .outG1(outG1), .outB1(outB1)
    );

    initial begin
        HCLK = 1'b0;
        forever #(clkPeriod / 2) HCLK = ~HCLK;
    end

    // ------------------------------------------------------------------------
    // golden line of test t holding pair idx, -1 if absent
    function automatic int findLine(input int t, input int idx);
        int found;
        int l;
        found = -1;
        for (l = 0; l < numLines; l++) begin
            if (int'(golden[l*fieldsPerLine]) == t &&
                int'(golden[l*fieldsPerLine+4]) == idx) begin
                found = l;
            end
        end
        return found;
    endfunction

    task automatic checkValue(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            errorCount++;
            $display("CHECK FAILED: %s, %s: expected %0d, actual %0d",
                     testNames[testIdx], what, expected, actual);
        end
    endtask

    // registered pixels read zero whenever no pair is written
    task automatic checkPixelsZero(input string when);
        checkValue({when, " outR0"}, 0, int'(outR0));
        checkValue({when, " outG0"}, 0, int'(outG0));
        checkValue({when, " outB0"}, 0, int'(outB0));
        checkValue({when, " outR1"}, 0, int'(outR1));
        checkValue({when, " outG1"}, 0, int'(outG1));
        checkValue({when, " outB1"}, 0, int'(outB1));
    endtask

    // controls from the frame, pixels for the address now on the bus
    task automatic driveInputs();
        int ctrlLine;
        int pixLine;
        int base;
        ctrlLine = findLine(testIdx, 0);
        pixLine  = findLine(testIdx, int'(pairAddr));
        if (ctrlLine >= 0) begin
            base        = ctrlLine * fieldsPerLine;
            operation   = golden[base+1][2:0];
            adjustSign  = golden[base+2][0];
            adjustValue = golden[base+3];
        end
        if (pixLine >= 0) begin
            base = pixLine * fieldsPerLine;
            inR0 = golden[base+5];
            inG0 = golden[base+6];
            inB0 = golden[base+7];
            inR1 = golden[base+8];
            inG1 = golden[base+9];
            inB1 = golden[base+10];
        end else begin
            errorCount++;
            $display("ERROR: %s: golden file has no pixels for pair %0d",
                     testNames[testIdx], pairAddr);
        end
    endtask

    task automatic checkOutputs();
        int line;
        int base;
        if (!HRESETn) begin
            checkValue("dataWrite during reset", 0, int'(dataWrite));
            checkValue("ctrlDone during reset", 0, int'(ctrlDone));
            checkPixelsZero("during reset");
        end else if (dataWrite) begin
            assert (writeCount == 0 || prevWrite) else begin
                errorCount++;
                $display("ERROR: %s: dataWrite dropped in the middle of the frame",
                         testNames[testIdx]);
            end
            line = findLine(testIdx, writeCount);   // nth strobe carries pair n
            assert (line >= 0) else begin
                errorCount++;
                $display("ERROR: %s: dataWrite number %0d comes after the frame ended",
                         testNames[testIdx], writeCount + 1);
            end
            if (line >= 0) begin
                base = line * fieldsPerLine;
                checkValue($sformatf("pair %0d outR0", writeCount), int'(golden[base+11]),
                           int'(outR0));
                checkValue($sformatf("pair %0d outG0", writeCount), int'(golden[base+12]),
                           int'(outG0));
                checkValue($sformatf("pair %0d outB0", writeCount), int'(golden[base+13]),
                           int'(outB0));
                checkValue($sformatf("pair %0d outR1", writeCount), int'(golden[base+14]),
                           int'(outR1));
                checkValue($sformatf("pair %0d outG1", writeCount), int'(golden[base+15]),
                           int'(outG1));
                checkValue($sformatf("pair %0d outB1", writeCount), int'(golden[base+16]),
                           int'(outB1));
            end
            if (writeCount < imagePkg::pairCount - 1) begin
                checkValue($sformatf("pair %0d pairAddr", writeCount), writeCount + 1,
                           int'(pairAddr));         // counter already on the next pair
            end
            checkValue($sformatf("pair %0d ctrlDone", writeCount),
                       int'(writeCount == imagePkg::pairCount - 1), int'(ctrlDone));
            doneSeen = doneSeen | ctrlDone;
            writeCount++;
        end else begin
            checkValue("ctrlDone without dataWrite", 0, int'(ctrlDone));
            checkPixelsZero("without dataWrite");
        end
        prevWrite = dataWrite;
    endtask

    task automatic serviceCycle();
        checkOutputs();                             // outputs are mid-cycle stable here
        driveInputs();
    endtask

    // ------------------------------------------------------------------------
    // one frame: reset, wait for done, then watch the bus stay quiet
    task automatic runFrame(input int t);
        int cycles;
        testIdx    = t;
        writeCount = 0;
        prevWrite  = 1'b0;
        doneSeen   = 1'b0;
        HRESETn    = 1'b0;                          // async, clears the DUT at once
        repeat (resetCycles) begin
            @(negedge HCLK);
            serviceCycle();
        end
        HRESETn = 1'b1;
        cycles  = 0;
        while (!doneSeen && cycles < frameLimit) begin
            @(negedge HCLK);
            serviceCycle();
            cycles++;
        end
        assert (doneSeen) else begin
            errorCount++;
            $display("ERROR: %s: ctrlDone did not rise within %0d cycles of reset release",
                     testNames[t], frameLimit);
        end
        repeat (quietCycles) begin
            @(negedge HCLK);
            serviceCycle();
        end
        checkValue("dataWrite count", imagePkg::pairCount, writeCount);
    endtask

    initial begin
        int t;
        HRESETn      = 1'b0;
        operation    = 3'd0;
        adjustSign   = 1'b0;
        adjustValue  = 8'd0;
        inR0         = 8'd0;
        inG0         = 8'd0;
        inB0         = 8'd0;
        inR1         = 8'd0;
        inG1         = 8'd0;
        inB1         = 8'd0;
        errorCount   = 0;
        testIdx      = 0;
        writeCount   = 0;
        prevWrite    = 1'b0;
        doneSeen     = 1'b0;
        testNames[0] = "brightness add";
        testNames[1] = "brightness subtract";
        testNames[2] = "invert";
        testNames[3] = "threshold";
        testNames[4] = "contrast";
        $readmemh("testbench/imageGolden.hex", golden);
        // last line must belong to the last test
        if (int'(golden[(numLines-1)*fieldsPerLine]) != numTests - 1) begin
            errorCount++;
            $display("ERROR: golden file testbench/imageGolden.hex is missing or incomplete");
        end else begin
            for (t = 0; t < numTests; t++) begin
                runFrame(t);
            end
        end
        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog, sized from the frame count
    initial begin
        #(watchdogTime);
        $display("ERROR: timeout, the run did not finish within %0d time units", watchdogTime);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
